// File: source/ccc_consts.svh
// CCC command codes, reserved address, RW bit, ENEC/DISEC flag bits and byte width
`ifndef CCC_CONSTS_SVH
`define CCC_CONSTS_SVH

// Bus byte width
`define CCC_BYTE_W          8

// Bit 7 of the code marks a direct CCC
`define CCC_DIRECT_BIT      7

// Broadcast codes
`define CCC_BCAST_ENEC      8'h00
`define CCC_BCAST_DISEC     8'h01
`define CCC_BCAST_RSTDAA    8'h06
`define CCC_BCAST_SETMWL    8'h09
`define CCC_BCAST_SETMRL    8'h0A

// Direct codes
`define CCC_DIRECT_ENEC     8'h80
`define CCC_DIRECT_DISEC    8'h81
`define CCC_DIRECT_SETDASA  8'h87
`define CCC_DIRECT_SETMWL   8'h89
`define CCC_DIRECT_SETMRL   8'h8A
`define CCC_DIRECT_GETMWL   8'h8B
`define CCC_DIRECT_GETMRL   8'h8C
`define CCC_DIRECT_GETPID   8'h8D
`define CCC_DIRECT_GETBCR   8'h8E
`define CCC_DIRECT_GETDCR   8'h8F

// Reserved broadcast address, always acked
`define CCC_RSVD_ADDR       7'h7E
// Read/write bit position in the address byte
`define CCC_RW_BIT          0

// ENEC/DISEC flag byte bit positions
`define CCC_EC_INT_BIT      0
`define CCC_EC_CR_BIT       1
`define CCC_EC_HJ_BIT       3

// Third GETMRL byte, max IBI payload size
`define CCC_MRL_IBI_BYTE    8'hFF

`endif

// File: source/ccc_pkg.sv
// Frame state type and shared byte, address, length and count types
`include "ccc_consts.svh"

package ccc_pkg;

  // One bus byte
  typedef logic [`CCC_BYTE_W-1:0] ccc_byte_t;
  // 7-bit target address
  typedef logic [6:0] ccc_addr_t;
  // Write or read length
  typedef logic [15:0] ccc_len_t;
  // Byte index or count, up to six response bytes
  typedef logic [2:0] ccc_cnt_t;

  // CCC frame sequencer states
  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitBusCond,
    WaitStop,
    Done
  } ccc_state_e;

endpackage

// File: source/ccc_frame_fsm.sv
// CCC frame sequencer: bus request lines, address matching and byte events
`timescale 1ns/1ps
`include "ccc_consts.svh"

module ccc_frame_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ccc_pkg::ccc_byte_t ccc_i,
  input  logic               ccc_valid_i,
  input  logic               bus_rstart_det_i,
  input  logic               bus_stop_det_i,
  input  logic               bus_rx_done_i,
  input  ccc_pkg::ccc_byte_t bus_rx_data_i,
  input  logic               bus_tx_done_i,
  input  ccc_pkg::ccc_addr_t target_dyn_address_i,
  input  ccc_pkg::ccc_addr_t target_sta_address_i,
  input  logic               target_dyn_address_valid_i,
  input  logic               target_sta_address_valid_i,
  input  ccc_pkg::ccc_byte_t tx_byte_i,
  input  logic               tx_last_i,
  output logic               bus_rx_req_bit_o,
  output logic               bus_rx_req_byte_o,
  output logic               bus_tx_req_bit_o,
  output logic               bus_tx_req_byte_o,
  output ccc_pkg::ccc_byte_t bus_tx_req_value_o,
  output logic               bus_tx_sel_od_pp_o,
  output logic               done_fsm_o,
  output ccc_pkg::ccc_byte_t cmd_code_o,
  output logic               addr_match_o,
  output logic               bcast_tbit_done_o,
  output logic               rx_byte_valid_o,
  output ccc_pkg::ccc_byte_t rx_byte_o,
  output ccc_pkg::ccc_cnt_t  rx_byte_idx_o,
  output logic               addr_ack_done_o,
  output logic               tx_byte_done_o
);
  import ccc_pkg::*;

  ccc_state_e state_q;
  ccc_state_e state_d;
  ccc_byte_t  cmd_code_q;
  ccc_addr_t  addr_q;
  logic       addr_rnw_q;
  logic       addr_valid_q;
  ccc_byte_t  rx_byte_q;
  ccc_cnt_t   rx_cnt_q;
  logic       is_direct;
  logic       our_addr;
  logic       rsvd_active;

  // Code handed over by the target FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_code_q <= '0;
    end else if (ccc_valid_i) begin
      cmd_code_q <= ccc_i;
    end
  end

  assign is_direct = cmd_code_q[`CCC_DIRECT_BIT];

  // Address byte after Sr; valid flag cleared at each new code
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_valid_q <= 1'b0;
    end else if (state_q == WaitCcc && ccc_valid_i) begin
      addr_valid_q <= 1'b0;
    end else if (state_q == RxAddr && bus_rx_done_i) begin
      addr_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RxAddr && bus_rx_done_i) begin
      addr_q     <= bus_rx_data_i[7:1];
      addr_rnw_q <= bus_rx_data_i[`CCC_RW_BIT];
    end
    // Data byte held until its T-bit completes
    if (state_q == RxData && bus_rx_done_i) begin
      rx_byte_q <= bus_rx_data_i;
    end
  end

  // Dynamic address wins; static only without a valid dynamic one
  always_comb begin
    if (target_dyn_address_valid_i) begin
      our_addr = (addr_q == target_dyn_address_i);
    end else if (target_sta_address_valid_i) begin
      our_addr = (addr_q == target_sta_address_i);
    end else begin
      our_addr = 1'b0;
    end
  end

  assign rsvd_active = addr_valid_q && (addr_q == `CCC_RSVD_ADDR);

  // Data byte index, restarts after each address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_cnt_q <= '0;
    end else if ((state_q == WaitCcc && ccc_valid_i) || (state_q == RxAddr && bus_rx_done_i)) begin
      rx_cnt_q <= '0;
    end else if (state_q == RxDataTbit && bus_rx_done_i && rx_cnt_q != 3'd7) begin
      rx_cnt_q <= rx_cnt_q + 3'd1;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:        state_d = WaitCcc;
      WaitCcc:     if (ccc_valid_i) state_d = RxTbit;
      RxTbit: begin
        // Broadcast data follows directly, direct CCC waits for Sr
        if (bus_rx_done_i) state_d = is_direct ? WaitBusCond : RxData;
      end
      RxAddr:      if (bus_rx_done_i) state_d = TxAddrAck;
      TxAddrAck: begin
        if (bus_tx_done_i) begin
          if (rsvd_active) state_d = WaitStop;
          else if (our_addr && addr_rnw_q) state_d = TxData;
          else if (our_addr) state_d = RxData;
          else state_d = WaitBusCond;
        end
      end
      RxData: begin
        if (bus_rstart_det_i) state_d = is_direct ? RxAddr : WaitStop;
        else if (bus_rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit:  if (bus_rx_done_i) state_d = RxData;
      TxData: begin
        if (bus_rstart_det_i) state_d = RxAddr;
        else if (bus_tx_done_i) state_d = TxDataTbit;
      end
      TxDataTbit:  if (bus_tx_done_i) state_d = tx_last_i ? WaitBusCond : TxData;
      WaitBusCond: if (bus_rstart_det_i) state_d = RxAddr;
      // Left only through the Stop override
      WaitStop:    state_d = WaitStop;
      Done:        state_d = Idle;
      default:     state_d = Idle;
    endcase
  end

  // Stop ends the CCC from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (bus_stop_det_i) begin
      state_q <= Done;
    end else begin
      state_q <= state_d;
    end
  end

  // Bus requests, held until the matching done pulse
  always_comb begin
    bus_rx_req_bit_o   = 1'b0;
    bus_rx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_value_o = '0;
    bus_tx_sel_od_pp_o = 1'b0;
    unique case (state_q)
      RxTbit, RxDataTbit: bus_rx_req_bit_o = 1'b1;
      RxAddr:             bus_rx_req_byte_o = 1'b1;
      // Drop the byte request in the Sr cycle
      RxData:             bus_rx_req_byte_o = !bus_rstart_det_i;
      TxAddrAck: begin
        // ACK is 0, open drain
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, !(our_addr || rsvd_active)};
      end
      TxData: begin
        bus_tx_req_byte_o  = 1'b1;
        bus_tx_req_value_o = tx_byte_i;
        bus_tx_sel_od_pp_o = 1'b1;
      end
      TxDataTbit: begin
        // T-bit 0 ends the read
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, !tx_last_i};
        bus_tx_sel_od_pp_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign done_fsm_o        = (state_q == Done);
  assign cmd_code_o        = cmd_code_q;
  assign addr_match_o      = addr_valid_q && our_addr;
  assign bcast_tbit_done_o = (state_q == RxTbit) && bus_rx_done_i;
  assign rx_byte_valid_o   = (state_q == RxDataTbit) && bus_rx_done_i && !rsvd_active;
  assign rx_byte_o         = rx_byte_q;
  assign rx_byte_idx_o     = rx_cnt_q;
  assign addr_ack_done_o   = (state_q == TxAddrAck) && bus_tx_done_i;
  // Byte plus its T-bit sent
  assign tx_byte_done_o    = (state_q == TxDataTbit) && bus_tx_done_i;

endmodule

// File: source/ccc_set_handler.sv
// SET CCC handler: SETMWL, SETMRL, ENEC, DISEC, SETDASA and RSTDAA outputs
`timescale 1ns/1ps
`include "ccc_consts.svh"

module ccc_set_handler (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ccc_pkg::ccc_byte_t cmd_code_i,
  input  logic               bcast_tbit_done_i,
  input  logic               rx_byte_valid_i,
  input  ccc_pkg::ccc_byte_t rx_byte_i,
  input  ccc_pkg::ccc_cnt_t  rx_byte_idx_i,
  output logic               set_mwl_o,
  output ccc_pkg::ccc_len_t  mwl_o,
  output logic               set_mrl_o,
  output ccc_pkg::ccc_len_t  mrl_o,
  output logic               enec_ibi_o,
  output logic               enec_crr_o,
  output logic               enec_hj_o,
  output logic               disec_ibi_o,
  output logic               disec_crr_o,
  output logic               disec_hj_o,
  output logic               set_dasa_valid_o,
  output ccc_pkg::ccc_addr_t set_dasa_o,
  output logic               rstdaa_o
);
  import ccc_pkg::*;

  logic first_byte;
  logic second_byte;

  assign first_byte  = rx_byte_valid_i && (rx_byte_idx_i == 3'd0);
  assign second_byte = rx_byte_valid_i && (rx_byte_idx_i == 3'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_mwl_o        <= 1'b0;
      mwl_o            <= '0;
      set_mrl_o        <= 1'b0;
      mrl_o            <= '0;
      enec_ibi_o       <= 1'b0;
      enec_crr_o       <= 1'b0;
      enec_hj_o        <= 1'b0;
      disec_ibi_o      <= 1'b0;
      disec_crr_o      <= 1'b0;
      disec_hj_o       <= 1'b0;
      set_dasa_valid_o <= 1'b0;
      rstdaa_o         <= 1'b0;
    end else begin
      // Pulses by default
      set_mwl_o        <= 1'b0;
      set_mrl_o        <= 1'b0;
      set_dasa_valid_o <= 1'b0;
      rstdaa_o         <= bcast_tbit_done_i && (cmd_code_i == `CCC_BCAST_RSTDAA);
      case (cmd_code_i)
        // Length MSB first, strobe on the low half
        `CCC_BCAST_SETMWL, `CCC_DIRECT_SETMWL: begin
          if (first_byte) mwl_o[15:8] <= rx_byte_i;
          if (second_byte) begin
            mwl_o[7:0] <= rx_byte_i;
            set_mwl_o  <= 1'b1;
          end
        end
        `CCC_BCAST_SETMRL, `CCC_DIRECT_SETMRL: begin
          if (first_byte) mrl_o[15:8] <= rx_byte_i;
          if (second_byte) begin
            mrl_o[7:0] <= rx_byte_i;
            set_mrl_o  <= 1'b1;
          end
        end
        `CCC_BCAST_ENEC, `CCC_DIRECT_ENEC: begin
          if (first_byte) begin
            enec_ibi_o <= rx_byte_i[`CCC_EC_INT_BIT];
            enec_crr_o <= rx_byte_i[`CCC_EC_CR_BIT];
            enec_hj_o  <= rx_byte_i[`CCC_EC_HJ_BIT];
          end
        end
        `CCC_BCAST_DISEC, `CCC_DIRECT_DISEC: begin
          if (first_byte) begin
            disec_ibi_o <= rx_byte_i[`CCC_EC_INT_BIT];
            disec_crr_o <= rx_byte_i[`CCC_EC_CR_BIT];
            disec_hj_o  <= rx_byte_i[`CCC_EC_HJ_BIT];
          end
        end
        `CCC_DIRECT_SETDASA: set_dasa_valid_o <= first_byte;
        default: begin
        end
      endcase
    end
  end

  // New dynamic address sits in bits 7:1
  always_ff @(posedge clk_i) begin
    if (first_byte && cmd_code_i == `CCC_DIRECT_SETDASA) begin
      set_dasa_o <= rx_byte_i[7:1];
    end
  end

endmodule

// File: source/ccc_get_handler.sv
// GET CCC handler: response byte count and MSB-first byte select
`timescale 1ns/1ps
`include "ccc_consts.svh"

module ccc_get_handler (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ccc_pkg::ccc_byte_t cmd_code_i,
  input  logic               addr_match_i,
  input  logic               addr_ack_done_i,
  input  logic               tx_byte_done_i,
  input  ccc_pkg::ccc_byte_t get_bcr_i,
  input  ccc_pkg::ccc_byte_t get_dcr_i,
  input  ccc_pkg::ccc_len_t  get_mwl_i,
  input  ccc_pkg::ccc_len_t  get_mrl_i,
  input  logic [47:0]        get_pid_i,
  output ccc_pkg::ccc_byte_t tx_byte_o,
  output logic               tx_last_o
);
  import ccc_pkg::*;

  ccc_cnt_t cnt_q;
  ccc_cnt_t cnt_init;

  // Bytes left, including the one on the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (addr_ack_done_i) begin
      cnt_q <= addr_match_i ? cnt_init : '0;
    end else if (tx_byte_done_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  // Unknown read sends a single zero byte
  assign tx_last_o = (cnt_q <= 3'd1);

  // Highest count picks the most significant byte
  always_comb begin
    cnt_init  = '0;
    tx_byte_o = '0;
    case (cmd_code_i)
      `CCC_DIRECT_GETBCR: begin
        cnt_init  = 3'd1;
        tx_byte_o = get_bcr_i;
      end
      `CCC_DIRECT_GETDCR: begin
        cnt_init  = 3'd1;
        tx_byte_o = get_dcr_i;
      end
      `CCC_DIRECT_GETMWL: begin
        cnt_init  = 3'd2;
        tx_byte_o = (cnt_q == 3'd2) ? get_mwl_i[15:8] : get_mwl_i[7:0];
      end
      `CCC_DIRECT_GETMRL: begin
        cnt_init = 3'd3;
        case (cnt_q)
          3'd3:    tx_byte_o = get_mrl_i[15:8];
          3'd2:    tx_byte_o = get_mrl_i[7:0];
          default: tx_byte_o = `CCC_MRL_IBI_BYTE;
        endcase
      end
      `CCC_DIRECT_GETPID: begin
        cnt_init = 3'd6;
        case (cnt_q)
          3'd6:    tx_byte_o = get_pid_i[47:40];
          3'd5:    tx_byte_o = get_pid_i[39:32];
          3'd4:    tx_byte_o = get_pid_i[31:24];
          3'd3:    tx_byte_o = get_pid_i[23:16];
          3'd2:    tx_byte_o = get_pid_i[15:8];
          default: tx_byte_o = get_pid_i[7:0];
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

// File: source/ccc_top.sv
// CCC handler top level: frame sequencer with SET and GET handlers
`timescale 1ns/1ps

module ccc_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ccc_pkg::ccc_byte_t ccc_i,
  input  logic               ccc_valid_i,
  output logic               done_fsm_o,
  input  logic               bus_rstart_det_i,
  input  logic               bus_stop_det_i,
  input  logic               bus_rx_done_i,
  input  ccc_pkg::ccc_byte_t bus_rx_data_i,
  output logic               bus_rx_req_bit_o,
  output logic               bus_rx_req_byte_o,
  input  logic               bus_tx_done_i,
  output logic               bus_tx_req_bit_o,
  output logic               bus_tx_req_byte_o,
  output ccc_pkg::ccc_byte_t bus_tx_req_value_o,
  output logic               bus_tx_sel_od_pp_o,
  input  ccc_pkg::ccc_addr_t target_dyn_address_i,
  input  logic               target_dyn_address_valid_i,
  input  ccc_pkg::ccc_addr_t target_sta_address_i,
  input  logic               target_sta_address_valid_i,
  input  ccc_pkg::ccc_byte_t get_bcr_i,
  input  ccc_pkg::ccc_byte_t get_dcr_i,
  input  ccc_pkg::ccc_len_t  get_mwl_i,
  input  ccc_pkg::ccc_len_t  get_mrl_i,
  input  logic [47:0]        get_pid_i,
  output logic               set_mwl_o,
  output ccc_pkg::ccc_len_t  mwl_o,
  output logic               set_mrl_o,
  output ccc_pkg::ccc_len_t  mrl_o,
  output logic               enec_ibi_o,
  output logic               enec_crr_o,
  output logic               enec_hj_o,
  output logic               disec_ibi_o,
  output logic               disec_crr_o,
  output logic               disec_hj_o,
  output logic               set_dasa_valid_o,
  output ccc_pkg::ccc_addr_t set_dasa_o,
  output logic               rstdaa_o
);
  import ccc_pkg::*;

  ccc_byte_t cmd_code;
  logic      addr_match;
  logic      bcast_tbit_done;
  logic      rx_byte_valid;
  ccc_byte_t rx_byte;
  ccc_cnt_t  rx_byte_idx;
  logic      addr_ack_done;
  logic      tx_byte_done;
  ccc_byte_t tx_byte;
  logic      tx_last;

  // Bus sequencing and byte events
  ccc_frame_fsm i_frame_fsm (
    .clk_i, .rst_ni, .ccc_i, .ccc_valid_i, .bus_rstart_det_i, .bus_stop_det_i,
    .bus_rx_done_i, .bus_rx_data_i, .bus_tx_done_i,
    .target_dyn_address_i, .target_sta_address_i,
    .target_dyn_address_valid_i, .target_sta_address_valid_i,
    .tx_byte_i (tx_byte),
    .tx_last_i (tx_last),
    .bus_rx_req_bit_o, .bus_rx_req_byte_o, .bus_tx_req_bit_o, .bus_tx_req_byte_o,
    .bus_tx_req_value_o, .bus_tx_sel_od_pp_o, .done_fsm_o,
    .cmd_code_o        (cmd_code),
    .addr_match_o      (addr_match),
    .bcast_tbit_done_o (bcast_tbit_done),
    .rx_byte_valid_o   (rx_byte_valid),
    .rx_byte_o         (rx_byte),
    .rx_byte_idx_o     (rx_byte_idx),
    .addr_ack_done_o   (addr_ack_done),
    .tx_byte_done_o    (tx_byte_done)
  );

  // Write CCCs
  ccc_set_handler i_set_handler (
    .clk_i, .rst_ni,
    .cmd_code_i        (cmd_code),
    .bcast_tbit_done_i (bcast_tbit_done),
    .rx_byte_valid_i   (rx_byte_valid),
    .rx_byte_i         (rx_byte),
    .rx_byte_idx_i     (rx_byte_idx),
    .set_mwl_o, .mwl_o, .set_mrl_o, .mrl_o,
    .enec_ibi_o, .enec_crr_o, .enec_hj_o,
    .disec_ibi_o, .disec_crr_o, .disec_hj_o,
    .set_dasa_valid_o, .set_dasa_o, .rstdaa_o
  );

  // Read CCCs
  ccc_get_handler i_get_handler (
    .clk_i, .rst_ni,
    .cmd_code_i      (cmd_code),
    .addr_match_i    (addr_match),
    .addr_ack_done_i (addr_ack_done),
    .tx_byte_done_i  (tx_byte_done),
    .get_bcr_i, .get_dcr_i, .get_mwl_i, .get_mrl_i, .get_pid_i,
    .tx_byte_o       (tx_byte),
    .tx_last_o       (tx_last)
  );

endmodule

// File: verif/ccc_checker.sv
// Bound assertions on the frame sequencer bus requests and done pulse
`timescale 1ns/1ps

module ccc_checker (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                bus_rx_req_bit_i,
  input logic                bus_rx_req_byte_i,
  input logic                bus_tx_req_bit_i,
  input logic                bus_tx_req_byte_i,
  input logic                done_fsm_i
);

  // One RX request kind at a time
  rx_kinds_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus_rx_req_bit_i && bus_rx_req_byte_i))
    else $error("RX bit and RX byte requests high together");

  // Bus is either driven or sampled, never both
  rx_tx_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((bus_tx_req_bit_i || bus_tx_req_byte_i) && (bus_rx_req_bit_i || bus_rx_req_byte_i)))
    else $error("TX request high together with an RX request");

  // Done is a single-cycle pulse
  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_fsm_i |=> !done_fsm_i)
    else $error("done_fsm_o high for more than one cycle");

endmodule

bind ccc_frame_fsm ccc_checker i_checker (
  .clk_i,
  .rst_ni,
  .bus_rx_req_bit_i  (bus_rx_req_bit_o),
  .bus_rx_req_byte_i (bus_rx_req_byte_o),
  .bus_tx_req_bit_i  (bus_tx_req_bit_o),
  .bus_tx_req_byte_i (bus_tx_req_byte_o),
  .done_fsm_i        (done_fsm_o)
);

// File: verif/ccc_tb.sv
// CCC handler testbench: clock, bus-layer model, CCC table, value check and watchdog
`timescale 1ns/1ps
`include "ccc_consts.svh"

module ccc_tb;
  import ccc_pkg::*;

  localparam int num_rows = 15;
  localparam int clk_period = 100;
  // Target identity and GET source values
  localparam logic [6:0]  sta_addr = 7'h2A;
  localparam logic [6:0]  dyn_addr = 7'h15;
  localparam logic [7:0]  bcr_val = 8'h66;
  localparam logic [7:0]  dcr_val = 8'hC4;
  localparam logic [15:0] mwl_val = 16'h1357;
  localparam logic [15:0] mrl_val = 16'h2468;
  localparam logic [47:0] pid_val = 48'hA1B2_C3D4_E5F6;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  ccc_byte_t ccc_i;
  logic      ccc_valid_i;
  logic      done_fsm_o;
  logic      bus_rstart_det_i, bus_stop_det_i, bus_rx_done_i, bus_tx_done_i;
  ccc_byte_t bus_rx_data_i;
  logic      bus_rx_req_bit_o, bus_rx_req_byte_o, bus_tx_req_bit_o, bus_tx_req_byte_o;
  ccc_byte_t bus_tx_req_value_o;
  logic      bus_tx_sel_od_pp_o;
  ccc_addr_t target_dyn_address_i, target_sta_address_i;
  logic      target_dyn_address_valid_i, target_sta_address_valid_i;
  ccc_byte_t get_bcr_i, get_dcr_i;
  ccc_len_t  get_mwl_i, get_mrl_i, mwl_o, mrl_o;
  logic [47:0] get_pid_i;
  logic      set_mwl_o, set_mrl_o, set_dasa_valid_o, rstdaa_o;
  logic      enec_ibi_o, enec_crr_o, enec_hj_o, disec_ibi_o, disec_crr_o, disec_hj_o;
  ccc_addr_t set_dasa_o;

  // CCC table, data bytes MSB first
  logic [7:0]  row_code [num_rows];
  logic [6:0]  row_addr [num_rows];
  logic        row_dyn_valid [num_rows];
  logic        row_ack [num_rows];
  int          row_len [num_rows];
  logic [47:0] row_data [num_rows];
  int          row_cnt = 0;

  int seed;
  int err_cnt = 0;
  // Pulse counters
  int n_mwl = 0;
  int n_mrl = 0;
  int n_dasa = 0;
  int n_rstdaa = 0;

  ccc_top i_dut (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (set_mwl_o) n_mwl <= n_mwl + 1;
      if (set_mrl_o) n_mrl <= n_mrl + 1;
      if (set_dasa_valid_o) n_dasa <= n_dasa + 1;
      if (rstdaa_o) n_rstdaa <= n_rstdaa + 1;
    end
  end

  task automatic check(input logic [47:0] actual, input logic [47:0] expected, input string what);
    if (actual !== expected) begin
      err_cnt++;
      $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic add_row(input logic [7:0] code, input logic [6:0] addr, input logic dyn_valid,
                         input logic ack, input int len, input logic [47:0] data);
    row_code[row_cnt]      = code;
    row_addr[row_cnt]      = addr;
    row_dyn_valid[row_cnt] = dyn_valid;
    row_ack[row_cnt]       = ack;
    row_len[row_cnt]       = len;
    row_data[row_cnt]      = data;
    row_cnt++;
  endtask

  // Bus layer answers 1 to 4 cycles after a request
  task automatic wait_request_and_delay();
    int d;
    @(negedge clk_i);
    while (!(bus_rx_req_bit_o || bus_rx_req_byte_o || bus_tx_req_bit_o || bus_tx_req_byte_o))
      @(negedge clk_i);
    d = 1 + int'($unsigned($random(seed)) % 4);
    repeat (d) @(posedge clk_i);
  endtask

  task automatic rx_transfer(input logic is_byte, input ccc_byte_t data);
    wait_request_and_delay();
    check(48'(bus_rx_req_byte_o), 48'(is_byte), "RX byte request");
    check(48'(bus_rx_req_bit_o), 48'(!is_byte), "RX bit request");
    bus_rx_data_i <= data;
    bus_rx_done_i <= 1'b1;
    @(posedge clk_i);
    bus_rx_done_i <= 1'b0;
  endtask

  task automatic tx_transfer(input logic is_byte, input logic push_pull,
                             output ccc_byte_t value);
    wait_request_and_delay();
    check(48'(bus_tx_req_byte_o), 48'(is_byte), "TX byte request");
    check(48'(bus_tx_req_bit_o), 48'(!is_byte), "TX bit request");
    // ACK open drain, read data and T-bits push-pull
    check(48'(bus_tx_sel_od_pp_o), 48'(push_pull), "TX drive mode");
    // Request value is held until done
    value = bus_tx_req_value_o;
    bus_tx_done_i <= 1'b1;
    @(posedge clk_i);
    bus_tx_done_i <= 1'b0;
  endtask

  task automatic send_rstart();
    @(posedge clk_i);
    bus_rstart_det_i <= 1'b1;
    @(posedge clk_i);
    bus_rstart_det_i <= 1'b0;
  endtask

  // Done must follow the Stop by exactly one cycle
  task automatic send_stop();
    @(posedge clk_i);
    bus_stop_det_i <= 1'b1;
    @(negedge clk_i);
    check(48'(done_fsm_o), 48'd0, "done_fsm_o before Stop sampled");
    @(posedge clk_i);
    bus_stop_det_i <= 1'b0;
    @(negedge clk_i);
    check(48'(done_fsm_o), 48'd1, "done_fsm_o one cycle after Stop");
    @(negedge clk_i);
    check(48'(done_fsm_o), 48'd0, "done_fsm_o single cycle");
  endtask

  // SET outputs, one cycle after the last data T-bit
  task automatic check_set(input int i);
    logic [7:0]  b0;
    logic [15:0] len;
    b0  = row_data[i][47:40];
    len = row_data[i][47:32];
    @(negedge clk_i);
    case (row_code[i])
      `CCC_BCAST_SETMWL, `CCC_DIRECT_SETMWL: begin
        check(48'(set_mwl_o), 48'd1, "set_mwl_o pulse");
        check(48'(mwl_o), 48'(len), "mwl_o value");
      end
      `CCC_BCAST_SETMRL, `CCC_DIRECT_SETMRL: begin
        check(48'(set_mrl_o), 48'd1, "set_mrl_o pulse");
        check(48'(mrl_o), 48'(len), "mrl_o value");
      end
      `CCC_BCAST_ENEC, `CCC_DIRECT_ENEC:
        check(48'({enec_hj_o, enec_crr_o, enec_ibi_o}),
              48'({b0[`CCC_EC_HJ_BIT], b0[`CCC_EC_CR_BIT], b0[`CCC_EC_INT_BIT]}), "ENEC flags");
      `CCC_BCAST_DISEC, `CCC_DIRECT_DISEC:
        check(48'({disec_hj_o, disec_crr_o, disec_ibi_o}),
              48'({b0[`CCC_EC_HJ_BIT], b0[`CCC_EC_CR_BIT], b0[`CCC_EC_INT_BIT]}), "DISEC flags");
      `CCC_DIRECT_SETDASA: begin
        check(48'(set_dasa_valid_o), 48'd1, "set_dasa_valid_o pulse");
        check(48'(set_dasa_o), 48'(b0[7:1]), "set_dasa_o value");
      end
      default: begin
      end
    endcase
  endtask

  task automatic run_row(input int i);
    logic [7:0] code;
    logic       direct;
    logic       is_get;
    logic       accepted;
    ccc_byte_t  b;
    ccc_byte_t  sent;
    int         mwl_base;
    int         mrl_base;
    int         dasa_base;
    int         rstdaa_base;
    code        = row_code[i];
    direct      = code[`CCC_DIRECT_BIT];
    is_get      = direct && (code >= `CCC_DIRECT_GETMWL);
    accepted    = !direct || !row_ack[i];
    mwl_base    = n_mwl;
    mrl_base    = n_mrl;
    dasa_base   = n_dasa;
    rstdaa_base = n_rstdaa;
    // Code held until the T-bit request shows up
    @(posedge clk_i);
    target_dyn_address_valid_i <= row_dyn_valid[i];
    ccc_i       <= code;
    ccc_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!bus_rx_req_bit_o) @(negedge clk_i);
    @(posedge clk_i);
    ccc_valid_i <= 1'b0;
    // Code T-bit, odd parity
    rx_transfer(1'b0, {7'h00, ~^code});
    @(negedge clk_i);
    check(48'(rstdaa_o), 48'(code == `CCC_BCAST_RSTDAA), "rstdaa_o after code T-bit");
    if (direct) begin
      send_rstart();
      rx_transfer(1'b1, {row_addr[i], is_get});
      tx_transfer(1'b0, 1'b0, sent);
      check(48'(sent), 48'(row_ack[i]), "address ACK bit");
    end
    if (accepted && is_get) begin
      for (int k = 0; k < row_len[i]; k++) begin
        tx_transfer(1'b1, 1'b1, sent);
        check(48'(sent), 48'(row_data[i][47 - 8 * k -: 8]), "GET response byte");
        tx_transfer(1'b0, 1'b1, sent);
        check(48'(sent), 48'(k != row_len[i] - 1), "GET T-bit");
      end
    end else if (accepted && row_len[i] > 0) begin
      for (int k = 0; k < row_len[i]; k++) begin
        b = row_data[i][47 - 8 * k -: 8];
        rx_transfer(1'b1, b);
        rx_transfer(1'b0, {7'h00, ~^b});
      end
      check_set(i);
    end
    send_stop();
    // Each SET pulse once per accepted frame, none otherwise
    check(48'(n_mwl - mwl_base),
          48'(accepted && (code == `CCC_BCAST_SETMWL || code == `CCC_DIRECT_SETMWL)),
          "set_mwl_o pulse count");
    check(48'(n_mrl - mrl_base),
          48'(accepted && (code == `CCC_BCAST_SETMRL || code == `CCC_DIRECT_SETMRL)),
          "set_mrl_o pulse count");
    check(48'(n_dasa - dasa_base), 48'(accepted && code == `CCC_DIRECT_SETDASA),
          "set_dasa_valid_o pulse count");
    check(48'(n_rstdaa - rstdaa_base), 48'(code == `CCC_BCAST_RSTDAA), "rstdaa_o pulse count");
  endtask

  initial begin
    seed                       = 32'h17535410;
    rst_ni                     = 1'b0;
    ccc_i                      = '0;
    ccc_valid_i                = 1'b0;
    bus_rstart_det_i           = 1'b0;
    bus_stop_det_i             = 1'b0;
    bus_rx_done_i              = 1'b0;
    bus_rx_data_i              = '0;
    bus_tx_done_i              = 1'b0;
    target_dyn_address_i       = dyn_addr;
    target_sta_address_i       = sta_addr;
    target_dyn_address_valid_i = 1'b0;
    target_sta_address_valid_i = 1'b1;
    get_bcr_i                  = bcr_val;
    get_dcr_i                  = dcr_val;
    get_mwl_i                  = mwl_val;
    get_mrl_i                  = mrl_val;
    get_pid_i                  = pid_val;
    // code, address, dyn valid, ACK bit, bytes, data
    add_row(`CCC_BCAST_SETMWL, 7'h00, 1'b0, 1'b0, 2, 48'h1234_0000_0000);
    add_row(`CCC_BCAST_SETMRL, 7'h00, 1'b0, 1'b0, 2, 48'h5678_0000_0000);
    add_row(`CCC_BCAST_ENEC, 7'h00, 1'b0, 1'b0, 1, 48'h0B00_0000_0000);
    add_row(`CCC_BCAST_DISEC, 7'h00, 1'b0, 1'b0, 1, 48'h0A00_0000_0000);
    add_row(`CCC_BCAST_RSTDAA, 7'h00, 1'b0, 1'b0, 0, 48'h0);
    add_row(`CCC_DIRECT_SETDASA, sta_addr, 1'b0, 1'b0, 1, 48'h6C00_0000_0000);
    add_row(`CCC_DIRECT_SETDASA, 7'h2B, 1'b0, 1'b1, 1, 48'h6C00_0000_0000);
    add_row(`CCC_DIRECT_SETMWL, dyn_addr, 1'b1, 1'b0, 2, 48'hABCD_0000_0000);
    add_row(`CCC_DIRECT_ENEC, dyn_addr, 1'b1, 1'b0, 1, 48'h0800_0000_0000);
    add_row(`CCC_DIRECT_GETPID, dyn_addr, 1'b1, 1'b0, 6, pid_val);
    add_row(`CCC_DIRECT_GETMRL, dyn_addr, 1'b1, 1'b0, 3, {mrl_val, `CCC_MRL_IBI_BYTE, 24'h0});
    add_row(`CCC_DIRECT_GETBCR, dyn_addr, 1'b1, 1'b0, 1, {bcr_val, 40'h0});
    // Static address ignored while a dynamic one is valid
    add_row(`CCC_DIRECT_GETDCR, sta_addr, 1'b1, 1'b1, 1, {dcr_val, 40'h0});
    add_row(`CCC_DIRECT_GETDCR, sta_addr, 1'b0, 1'b0, 1, {dcr_val, 40'h0});
    add_row(`CCC_DIRECT_GETMWL, dyn_addr, 1'b1, 1'b0, 2, {mwl_val, 32'h0});
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < row_cnt; i++) begin
      run_row(i);
    end
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog, 200 cycles per table row
  initial begin
    #(num_rows * 200 * clk_period);
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout: CCC frames did not finish within %0d cycles", num_rows * 200);
  end

endmodule

// File: sim.f
+incdir+source
source/ccc_pkg.sv
source/ccc_frame_fsm.sv
source/ccc_set_handler.sv
source/ccc_get_handler.sv
source/ccc_top.sv
verif/ccc_checker.sv
verif/ccc_tb.sv

// File: run.sh
#!/bin/sh
# Build the CCC testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module ccc_tb \
  -f sim.f -o ccc_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/ccc_sim > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed, see sim.log"; exit 1; }
